// File: logic/fp_fmt_pkg.sv
`default_nettype none

package fp_fmt_pkg;

  // FP32 field widths
  localparam int MANT_W = 23;
  localparam int EXP_W  = 8;

  // Unrounded operand from the divider / square root datapath
  localparam int MANT_IN_W = 28;  // Hidden bit, 23 fraction bits, 4 round bits
  localparam int EXP_IN_W  = 10;  // Signed, biased

  localparam int FP16_MANT_W = 10;
  localparam int FP16_EXP_W  = 5;

  localparam int EXP_MAX32 = 255;  // All-ones exponent fields
  localparam int EXP_MAX16 = 31;

  // Canonical quiet NaNs, positive
  localparam logic [31:0] QNAN32 = 32'h7fc0_0000;
  localparam logic [15:0] QNAN16 = 16'h7e00;
  localparam logic [15:0] BOX16  = 16'hffff;  // Upper half of a boxed FP16 result

  // Result word, read as FP32 or as NaN-boxed FP16
  typedef union packed {
    struct packed {
      logic                   sign;
      logic [EXP_W-1:0]       exp;
      logic [MANT_W-1:0]      frac;
    } fp32;
    struct packed {
      logic [15:0]            box;
      logic                   sign;
      logic [FP16_EXP_W-1:0]  exp;
      logic [FP16_MANT_W-1:0] frac;
    } fp16;
  } fp_word_u;

endpackage

`default_nettype wire

// File: logic/norm_ctrl_pkg.sv
`default_nettype none

package norm_ctrl_pkg;

  // Rounding mode codes, RISC-V frm encoding
  localparam logic [2:0] RM_RNE = 3'd0;  // Nearest, ties to even
  localparam logic [2:0] RM_RTZ = 3'd1;  // Toward zero
  localparam logic [2:0] RM_RDN = 3'd2;  // Toward -inf
  localparam logic [2:0] RM_RUP = 3'd3;  // Toward +inf
  localparam logic [2:0] RM_RMM = 3'd4;  // Nearest, ties away

  // Bit positions in fflags {NV, DZ, OF, UF, NX}
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  // Denormal right shift, past this every bit is sticky anyway
  localparam int SHIFT_MAX = 27;
  localparam int SHIFT_W   = 5;

endpackage

`default_nettype wire

// File: logic/norm_if.sv
`timescale 1ns/10ps
`default_nettype none

// Held operand between the shift register and the rounder
interface norm_if
  import fp_fmt_pkg::*;
();

  logic [MANT_W:0]              mant;    // Hidden bit on top
  logic [MANT_IN_W-MANT_W-2:0]  rbits;   // Round bits below the FP32 LSB
  logic [EXP_W-1:0]             exp;     // Biased, zero once denormal
  logic                         sign;
  logic                         sticky;  // OR of every bit shifted out
  logic                         uf;      // Tiny before rounding

  // Written by mant_shift_reg
  modport shift_src (
    output mant, rbits, exp, sign, sticky, uf
  );

  // Read by round_pack at capture
  modport round_dst (
    input mant, rbits, exp, sign, sticky, uf
  );

endinterface

`default_nettype wire

// File: logic/special_case_classify.sv
`timescale 1ns/10ps
`default_nettype none

module special_case_classify
  import fp_fmt_pkg::*;
  import norm_ctrl_pkg::*;
(
  input  logic [MANT_IN_W-1:0]       mant_in,
  input  logic signed [EXP_IN_W-1:0] exp_in,
  input  logic                       sign_in,
  input  logic                       op_div,
  input  logic                       op_sqrt,
  input  logic                       inf_a,
  input  logic                       inf_b,
  input  logic                       zero_a,
  input  logic                       zero_b,
  input  logic                       nan_a,
  input  logic                       nan_b,
  input  logic                       snan,
  input  logic                       fmt_fp16,
  output logic                       is_special,
  output fp_word_u                   special_word,
  output logic [4:0]                 special_flags,
  output logic [SHIFT_W-1:0]         shift_cnt
);

  logic                       res_nan;
  logic                       res_inf;
  logic                       res_zero;
  logic                       exp_ovf;     // Exponent already at all-ones
  logic signed [EXP_IN_W+1:0] shift_need;  // Shifts to reach exponent 1

  assign exp_ovf = fmt_fp16 ? (exp_in >= EXP_MAX16) : (exp_in >= EXP_MAX32);

  //////////////////////////////////////////////////////////////////////
  // Special operand precedence, first match wins
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    res_nan       = 1'b0;
    res_inf       = 1'b0;
    res_zero      = 1'b0;
    special_flags = '0;
    if (nan_a || nan_b)
    begin
      res_nan                = 1'b1;
      special_flags[FLAG_NV] = snan;  // Only signaling NaN raises NV
    end
    else if (inf_a)
    begin
      if ((op_div && inf_b) || (op_sqrt && sign_in))  // inf/inf, sqrt(-inf)
      begin
        res_nan                = 1'b1;
        special_flags[FLAG_NV] = 1'b1;
      end
      else
      begin
        res_inf                = 1'b1;
        special_flags[FLAG_OF] = 1'b1;
      end
    end
    else if (op_div && inf_b)
      res_zero = 1'b1;  // x/inf
    else if (zero_a)
    begin
      if (op_div && zero_b)
      begin
        res_nan                = 1'b1;  // 0/0
        special_flags[FLAG_NV] = 1'b1;
      end
      else
        res_zero = 1'b1;
    end
    else if (op_div && zero_b)
    begin
      res_inf                = 1'b1;  // x/0
      special_flags[FLAG_DZ] = 1'b1;
    end
    else if (op_sqrt && sign_in)
    begin
      res_nan                = 1'b1;
      special_flags[FLAG_NV] = 1'b1;
    end
    else if (exp_ovf)
    begin
      res_inf                = 1'b1;
      special_flags[FLAG_OF] = 1'b1;
    end
  end

  assign is_special = res_nan | res_inf | res_zero;

  // Pack the special pattern in the selected format
  always_comb
  begin
    if (res_nan)
      special_word = fmt_fp16 ? {BOX16, QNAN16} : QNAN32;
    else if (fmt_fp16)
    begin
      special_word.fp16.box  = BOX16;
      special_word.fp16.sign = sign_in;
      special_word.fp16.exp  = res_inf ? '1 : '0;
      special_word.fp16.frac = '0;
    end
    else
    begin
      special_word.fp32.sign = sign_in;
      special_word.fp32.exp  = res_inf ? '1 : '0;
      special_word.fp32.frac = '0;
    end
  end

  // 0.1x needs one shift more since it loses an exponent step first
  assign shift_need = 1 - exp_in + $signed({1'b0, ~mant_in[MANT_IN_W-1]});

  always_comb
  begin
    if (is_special || shift_need <= 0)
      shift_cnt = '0;
    else if (shift_need >= SHIFT_MAX)
      shift_cnt = SHIFT_W'(SHIFT_MAX);  // Saturate
    else
      shift_cnt = shift_need[SHIFT_W-1:0];
  end

endmodule

`default_nettype wire

// File: logic/denorm_shift_counter.sv
`timescale 1ns/10ps
`default_nettype none

module denorm_shift_counter
  import norm_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               load,
  input  logic [SHIFT_W-1:0] shift_cnt,
  input  logic               shift,
  output logic               done
);

  logic [SHIFT_W-1:0] cnt;  // Remaining right shifts

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt <= '0;
    else if (load)
      cnt <= shift_cnt;
    else if (shift && (cnt != '0))
      cnt <= cnt - 1'b1;  // Holds at zero
  end

  assign done = (cnt == '0);

endmodule

`default_nettype wire

// File: logic/mant_shift_reg.sv
`timescale 1ns/10ps
`default_nettype none

module mant_shift_reg
  import fp_fmt_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load,
  input  logic                       shift,
  input  logic [MANT_IN_W-1:0]       mant_in,
  input  logic signed [EXP_IN_W-1:0] exp_in,
  input  logic                       sign_in,
  norm_if.shift_src                  nif
);

  logic [MANT_IN_W-1:0]       norm_mant;
  logic signed [EXP_IN_W-1:0] norm_exp;
  logic                       tiny;  // Lands below exponent 1

  //////////////////////////////////////////////////////////////////////
  // Load-time normalization
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (mant_in[MANT_IN_W-1])
    begin
      norm_mant = mant_in;  // 1.x as is
      norm_exp  = exp_in;
    end
    else
    begin
      norm_mant = {mant_in[MANT_IN_W-2:0], 1'b0};  // 0.1x up by one
      norm_exp  = exp_in - 1;
    end
  end

  assign tiny = (norm_exp <= 0);

  // Operand payload
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      {nif.mant, nif.rbits} <= norm_mant;
      nif.exp               <= tiny ? '0 : norm_exp[EXP_W-1:0];
      nif.sign              <= sign_in;
    end
    else if (shift)
      {nif.mant, nif.rbits} <= {1'b0, nif.mant, nif.rbits[MANT_IN_W-MANT_W-2:1]};
  end

  // Sticky and underflow state
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      nif.sticky <= 1'b0;
      nif.uf     <= 1'b0;
    end
    else if (load)
    begin
      nif.sticky <= 1'b0;
      nif.uf     <= tiny;
    end
    else if (shift)
      nif.sticky <= nif.sticky | nif.rbits[0];  // Bit falling off the end
  end

endmodule

`default_nettype wire

// File: logic/round_pack.sv
`timescale 1ns/10ps
`default_nettype none

module round_pack
  import fp_fmt_pkg::*;
  import norm_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        capture,
  input  logic        is_special,
  input  fp_word_u    special_word,
  input  logic [4:0]  special_flags,
  input  logic [2:0]  rnd_mode,
  input  logic        fmt_fp16,
  norm_if.round_dst   nif,
  output logic [31:0] result,
  output logic [4:0]  fflags
);

  logic              lsb;
  logic              guard;
  logic              rnd;
  logic              stk;
  logic              inexact;
  logic              round_up;
  logic [MANT_W+1:0] rnd_inc;   // One at the format LSB
  logic [MANT_W+1:0] mant_sum;  // Carry, hidden bit, fraction
  logic [EXP_W-1:0]  exp_rnd;
  logic              ovf_rnd;
  fp_word_u          calc_word;
  logic [4:0]        calc_flags;

  //////////////////////////////////////////////////////////////////////
  // Guard, round and sticky at the format LSB
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    if (fmt_fp16)
    begin
      lsb   = nif.mant[MANT_W-FP16_MANT_W];
      guard = nif.mant[MANT_W-FP16_MANT_W-1];
      rnd   = nif.mant[MANT_W-FP16_MANT_W-2];
      stk   = (|nif.mant[MANT_W-FP16_MANT_W-3:0]) | (|nif.rbits) | nif.sticky;
    end
    else
    begin
      lsb   = nif.mant[0];
      guard = nif.rbits[3];
      rnd   = nif.rbits[2];
      stk   = (|nif.rbits[1:0]) | nif.sticky;
    end
  end

  assign inexact = guard | rnd | stk;

  always_comb
  begin
    case (rnd_mode)
      RM_RNE:  round_up = guard & (rnd | stk | lsb);
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = inexact & nif.sign;
      RM_RUP:  round_up = inexact & ~nif.sign;
      RM_RMM:  round_up = guard;
      default: round_up = 1'b0;  // Reserved codes truncate
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Increment and renormalize
  //////////////////////////////////////////////////////////////////////
  assign rnd_inc  = fmt_fp16 ? ((MANT_W+2)'(round_up) << (MANT_W - FP16_MANT_W))
                             : (MANT_W+2)'(round_up);
  assign mant_sum = {1'b0, nif.mant} + rnd_inc;

  // Carry out leaves an all-zero fraction, so only the exponent moves
  // Denormal reaching the hidden bit becomes the smallest normal
  assign exp_rnd = nif.uf ? {{(EXP_W-1){1'b0}}, mant_sum[MANT_W]}
                          : nif.exp + mant_sum[MANT_W+1];

  assign ovf_rnd = fmt_fp16 ? (exp_rnd == EXP_MAX16) : (exp_rnd == EXP_MAX32);

  always_comb
  begin
    if (fmt_fp16)
    begin
      calc_word.fp16.box  = BOX16;
      calc_word.fp16.sign = nif.sign;
      calc_word.fp16.exp  = exp_rnd[FP16_EXP_W-1:0];
      calc_word.fp16.frac = mant_sum[MANT_W-1:MANT_W-FP16_MANT_W];
    end
    else
    begin
      calc_word.fp32.sign = nif.sign;
      calc_word.fp32.exp  = exp_rnd;
      calc_word.fp32.frac = mant_sum[MANT_W-1:0];
    end
  end

  always_comb
  begin
    calc_flags          = '0;     // NV and DZ only come from specials
    calc_flags[FLAG_OF] = ovf_rnd;  // Rounded into all-ones
    calc_flags[FLAG_UF] = nif.uf & inexact;
    calc_flags[FLAG_NX] = inexact;
  end

  // Output registers, held until the next capture
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result <= '0;
      fflags <= '0;
    end
    else if (capture)
    begin
      result <= is_special ? special_word : calc_word;  // Special wins
      fflags <= is_special ? special_flags : calc_flags;
    end
  end

endmodule

`default_nettype wire

// File: logic/norm_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module norm_fsm (
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  logic done,
  output logic load,
  output logic shift,
  output logic capture,
  output logic ack
);

  enum logic [1:0] {IDLE, SHIFT, HOLD} state, state_nxt;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= IDLE;
      ack   <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      ack   <= (state_nxt == HOLD);  // High from capture until req drops
    end
  end

  always_comb
  begin
    state_nxt = state;
    load      = 1'b0;
    shift     = 1'b0;
    capture   = 1'b0;
    case (state)
      IDLE:
      begin
        if (req)
        begin
          load      = 1'b1;  // Operand and shift count in
          state_nxt = SHIFT;
        end
      end
      SHIFT:
      begin
        if (done)
        begin
          capture   = 1'b1;
          state_nxt = HOLD;
        end
        else
          shift = 1'b1;  // One bit per cycle
      end
      HOLD:
      begin
        if (!req)
          state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/norm_round_top.sv
`timescale 1ns/10ps
`default_nettype none

module norm_round_top
  import fp_fmt_pkg::*;
  import norm_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       req,
  output logic                       ack,
  input  logic [MANT_IN_W-1:0]       mant_in,
  input  logic signed [EXP_IN_W-1:0] exp_in,
  input  logic                       sign_in,
  input  logic                       op_div,
  input  logic                       op_sqrt,
  input  logic                       inf_a,
  input  logic                       inf_b,
  input  logic                       zero_a,
  input  logic                       zero_b,
  input  logic                       nan_a,
  input  logic                       nan_b,
  input  logic                       snan,
  input  logic [2:0]                 rnd_mode,
  input  logic                       fmt_fp16,  // 0 selects FP32
  output logic [31:0]                result,
  output logic [4:0]                 fflags
);

  logic               load;
  logic               shift;
  logic               capture;
  logic               done;
  logic               is_special;
  fp_word_u           special_word;
  logic [4:0]         special_flags;
  logic [SHIFT_W-1:0] shift_cnt;

  norm_if u_nif ();

  norm_fsm u_fsm (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .done    (done),
    .load    (load),
    .shift   (shift),
    .capture (capture),
    .ack     (ack)
  );

  denorm_shift_counter u_cnt (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .shift_cnt (shift_cnt),
    .shift     (shift),
    .done      (done)
  );

  special_case_classify u_cls (
    .mant_in       (mant_in),
    .exp_in        (exp_in),
    .sign_in       (sign_in),
    .op_div        (op_div),
    .op_sqrt       (op_sqrt),
    .inf_a         (inf_a),
    .inf_b         (inf_b),
    .zero_a        (zero_a),
    .zero_b        (zero_b),
    .nan_a         (nan_a),
    .nan_b         (nan_b),
    .snan          (snan),
    .fmt_fp16      (fmt_fp16),
    .is_special    (is_special),
    .special_word  (special_word),
    .special_flags (special_flags),
    .shift_cnt     (shift_cnt)
  );

  mant_shift_reg u_sreg (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .shift   (shift),
    .mant_in (mant_in),
    .exp_in  (exp_in),
    .sign_in (sign_in),
    .nif     (u_nif.shift_src)
  );

  round_pack u_rnd (
    .clk           (clk),
    .rst           (rst),
    .capture       (capture),
    .is_special    (is_special),
    .special_word  (special_word),
    .special_flags (special_flags),
    .rnd_mode      (rnd_mode),
    .fmt_fp16      (fmt_fp16),
    .nif           (u_nif.round_dst),
    .result        (result),
    .fflags        (fflags)
  );

endmodule

`default_nettype wire

// File: tb/tb_norm_round.sv
`timescale 1ns/10ps
`default_nettype none

module tb_norm_round
  import norm_ctrl_pkg::*;
();

  localparam int TIMEOUT = 60;  // Poll limit in cycles

  // Special flag vector {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b}
  localparam logic [6:0] SP_NONE   = 7'b0000000;
  localparam logic [6:0] SP_NAN_A  = 7'b1000000;
  localparam logic [6:0] SP_NAN_B  = 7'b0100000;
  localparam logic [6:0] SP_SNAN   = 7'b0010000;
  localparam logic [6:0] SP_INF_A  = 7'b0001000;
  localparam logic [6:0] SP_INF_B  = 7'b0000100;
  localparam logic [6:0] SP_ZERO_A = 7'b0000010;
  localparam logic [6:0] SP_ZERO_B = 7'b0000001;

  localparam logic [1:0] OP_DIV  = 2'b10;  // {op_div, op_sqrt}
  localparam logic [1:0] OP_SQRT = 2'b01;
  localparam logic       FP32    = 1'b0;
  localparam logic       FP16    = 1'b1;

  // Expected fflags {NV, DZ, OF, UF, NX}
  localparam logic [4:0] FLG_NONE = 5'b00000;
  localparam logic [4:0] FLG_NV   = 5'b10000;
  localparam logic [4:0] FLG_DZ   = 5'b01000;
  localparam logic [4:0] FLG_OF   = 5'b00100;
  localparam logic [4:0] FLG_NX   = 5'b00001;
  localparam logic [4:0] FLG_UNX  = 5'b00011;  // Tiny and inexact
  localparam logic [4:0] FLG_OFNX = 5'b00101;

  logic              clk;
  logic              rst;
  logic              req;
  logic              ack;
  logic [27:0]       mant_in;
  logic signed [9:0] exp_in;
  logic              sign_in;
  logic              op_div;
  logic              op_sqrt;
  logic              inf_a;
  logic              inf_b;
  logic              zero_a;
  logic              zero_b;
  logic              nan_a;
  logic              nan_b;
  logic              snan;
  logic [2:0]        rnd_mode;
  logic              fmt_fp16;
  logic [31:0]       result;
  logic [4:0]        fflags;

  // Stimulus and expected value table as parallel queues
  logic [27:0]       q_mant[$];
  logic signed [9:0] q_exp[$];
  logic              q_sign[$];
  logic [1:0]        q_op[$];
  logic [6:0]        q_spec[$];
  logic [2:0]        q_rm[$];
  logic              q_fmt[$];
  logic [31:0]       q_res[$];
  logic [4:0]        q_flg[$];

  int checks;
  int errors;
  int timeouts;
  int seed_val;

  norm_round_top DUT (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .ack      (ack),
    .mant_in  (mant_in),
    .exp_in   (exp_in),
    .sign_in  (sign_in),
    .op_div   (op_div),
    .op_sqrt  (op_sqrt),
    .inf_a    (inf_a),
    .inf_b    (inf_b),
    .zero_a   (zero_a),
    .zero_b   (zero_b),
    .nan_a    (nan_a),
    .nan_b    (nan_b),
    .snan     (snan),
    .rnd_mode (rnd_mode),
    .fmt_fp16 (fmt_fp16),
    .result   (result),
    .fflags   (fflags)
  );

  always #5 clk = ~clk;  // 10 ns period

  task add_vec(input logic [27:0] m, input logic signed [9:0] e, input logic s,
               input logic [1:0] op, input logic [6:0] sp, input logic [2:0] rm,
               input logic fmt, input logic [31:0] res, input logic [4:0] flg);
    begin
      q_mant.push_back(m);
      q_exp.push_back(e);
      q_sign.push_back(s);
      q_op.push_back(op);
      q_spec.push_back(sp);
      q_rm.push_back(rm);
      q_fmt.push_back(fmt);
      q_res.push_back(res);
      q_flg.push_back(flg);
    end
  endtask

  task check_val(input string name, input logic [31:0] want, input logic [31:0] got);
    begin
      checks++;
      if (got !== want)
      begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, want, got);
      end
    end
  endtask

  // Polls ack once per cycle 1 ns after the edge
  task wait_for_ack(input logic level, input int idx);
    int n;
    begin
      n = 0;
      while (ack !== level && n < TIMEOUT)
      begin
        @(posedge clk);
        #1;
        n++;
      end
      if (ack !== level)
      begin
        timeouts++;
        $display("timeout at %0t: ack never went to %b on entry %0d", $time, level, idx);
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operands with their expected result words
  //////////////////////////////////////////////////////////////////////
  task build_table;
    begin
      // Specials and precedence
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_NAN_A, RM_RNE, FP32, 32'h7fc00000, FLG_NONE);
      add_vec(28'h8000000, 127, 1, OP_DIV, SP_NAN_B|SP_SNAN, RM_RNE, FP32, 32'h7fc00000, FLG_NV);
      add_vec(28'h8000000, 15, 0, OP_SQRT, SP_NAN_A|SP_SNAN, RM_RNE, FP16, 32'hffff7e00, FLG_NV);
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_NAN_A|SP_INF_A, RM_RNE, FP32, 32'h7fc00000, FLG_NONE);
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_INF_A|SP_INF_B, RM_RNE, FP32, 32'h7fc00000, FLG_NV);
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_ZERO_A|SP_ZERO_B, RM_RNE, FP32, 32'h7fc00000, FLG_NV);
      add_vec(28'h8000000, 127, 1, OP_SQRT, SP_NONE, RM_RNE, FP32, 32'h7fc00000, FLG_NV);
      add_vec(28'h8000000, 15, 1, OP_SQRT, SP_INF_A, RM_RNE, FP16, 32'hffff7e00, FLG_NV);
      add_vec(28'h8000000, 127, 1, OP_DIV, SP_ZERO_B, RM_RNE, FP32, 32'hff800000, FLG_DZ);
      add_vec(28'h8000000, 15, 0, OP_DIV, SP_ZERO_B, RM_RNE, FP16, 32'hffff7c00, FLG_DZ);
      add_vec(28'h8000000, 127, 1, OP_DIV, SP_INF_B, RM_RNE, FP32, 32'h80000000, FLG_NONE);
      add_vec(28'h8000000, 15, 0, OP_DIV, SP_INF_B, RM_RNE, FP16, 32'hffff0000, FLG_NONE);
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_INF_A, RM_RNE, FP32, 32'h7f800000, FLG_OF);
      add_vec(28'h8000000, 15, 0, OP_SQRT, SP_INF_A, RM_RNE, FP16, 32'hffff7c00, FLG_OF);
      add_vec(28'h8000000, 127, 1, OP_DIV, SP_ZERO_A, RM_RNE, FP32, 32'h80000000, FLG_NONE);
      // Exponent at or past the format maximum
      add_vec(28'h8000000, 255, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h7f800000, FLG_OF);
      add_vec(28'h8000000, 300, 1, OP_DIV, SP_NONE, RM_RNE, FP32, 32'hff800000, FLG_OF);
      add_vec(28'h8000000, 31, 1, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hfffffc00, FLG_OF);
      // FP32 normal ties with an even LSB under every mode
      add_vec(28'h8000000, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h3f800000, FLG_NONE);
      add_vec(28'h8000008, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h3f800000, FLG_NX);
      add_vec(28'h8000008, 127, 0, OP_DIV, SP_NONE, RM_RTZ, FP32, 32'h3f800000, FLG_NX);
      add_vec(28'h8000008, 127, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h3f800001, FLG_NX);
      add_vec(28'h8000008, 127, 0, OP_DIV, SP_NONE, RM_RDN, FP32, 32'h3f800000, FLG_NX);
      add_vec(28'h8000008, 127, 0, OP_DIV, SP_NONE, RM_RMM, FP32, 32'h3f800001, FLG_NX);
      add_vec(28'h8000008, 127, 1, OP_DIV, SP_NONE, RM_RDN, FP32, 32'hbf800001, FLG_NX);
      add_vec(28'h8000008, 127, 1, OP_DIV, SP_NONE, RM_RUP, FP32, 32'hbf800000, FLG_NX);
      add_vec(28'h8000008, 127, 1, OP_DIV, SP_NONE, RM_RMM, FP32, 32'hbf800001, FLG_NX);
      add_vec(28'h8000018, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h3f800002, FLG_NX);
      add_vec(28'h8000007, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h3f800000, FLG_NX);
      add_vec(28'h800000c, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h3f800001, FLG_NX);
      // 0.1x mantissas lose one exponent step
      add_vec(28'h6000000, 128, 0, OP_SQRT, SP_NONE, RM_RNE, FP32, 32'h3fc00000, FLG_NONE);
      add_vec(28'h4000003, 128, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h3f800001, FLG_NX);
      add_vec(28'h4000003, 128, 1, OP_DIV, SP_NONE, RM_RNE, FP32, 32'hbf800000, FLG_NX);
      // Carry into the exponent and rounding into infinity
      add_vec(28'hfffffff, 127, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h40000000, FLG_NX);
      add_vec(28'hfffffff, 127, 0, OP_DIV, SP_NONE, RM_RTZ, FP32, 32'h3fffffff, FLG_NX);
      add_vec(28'hfffffff, 254, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h7f800000, FLG_OFNX);
      add_vec(28'hfffffff, 254, 1, OP_DIV, SP_NONE, RM_RTZ, FP32, 32'hff7fffff, FLG_NX);
      // FP16 normal with the guard at mant_in[16]
      add_vec(28'h8000000, 15, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff3c00, FLG_NONE);
      add_vec(28'h8010000, 15, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff3c00, FLG_NX);
      add_vec(28'h8010000, 15, 0, OP_DIV, SP_NONE, RM_RMM, FP16, 32'hffff3c01, FLG_NX);
      add_vec(28'h8010000, 15, 1, OP_DIV, SP_NONE, RM_RDN, FP16, 32'hffffbc01, FLG_NX);
      add_vec(28'h8010000, 15, 1, OP_DIV, SP_NONE, RM_RUP, FP16, 32'hffffbc00, FLG_NX);
      add_vec(28'h8000001, 15, 0, OP_DIV, SP_NONE, RM_RUP, FP16, 32'hffff3c01, FLG_NX);
      add_vec(28'hfff0000, 15, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff4000, FLG_NX);
      add_vec(28'hfff0000, 30, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff7c00, FLG_OFNX);
      add_vec(28'h4000000, 16, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff3c00, FLG_NONE);
      // FP32 denormals from short and saturated shifts
      add_vec(28'h8000000, 0, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h00400000, FLG_NONE);
      add_vec(28'h8000008, 0, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h00400000, FLG_UNX);
      add_vec(28'h8000008, 0, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h00400001, FLG_UNX);
      add_vec(28'h8000001, -20, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h00000004, FLG_UNX);
      add_vec(28'h8000001, -20, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h00000005, FLG_UNX);
      add_vec(28'h8000001, -20, 1, OP_DIV, SP_NONE, RM_RDN, FP32, 32'h80000005, FLG_UNX);
      add_vec(28'h8000000, -23, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h00000000, FLG_UNX);
      add_vec(28'h8000000, -23, 0, OP_DIV, SP_NONE, RM_RMM, FP32, 32'h00000001, FLG_UNX);
      add_vec(28'h8000000, -26, 1, OP_DIV, SP_NONE, RM_RDN, FP32, 32'h80000001, FLG_UNX);
      add_vec(28'h8000000, -100, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h00000001, FLG_UNX);
      add_vec(28'h8000000, -100, 1, OP_DIV, SP_NONE, RM_RTZ, FP32, 32'h80000000, FLG_UNX);
      add_vec(28'hfffffff, 0, 0, OP_DIV, SP_NONE, RM_RNE, FP32, 32'h00800000, FLG_UNX);
      add_vec(28'h4000001, 1, 0, OP_DIV, SP_NONE, RM_RUP, FP32, 32'h00400001, FLG_UNX);
      // FP16 denormals
      add_vec(28'h8000000, 0, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff0200, FLG_NONE);
      add_vec(28'h8000001, -5, 0, OP_DIV, SP_NONE, RM_RUP, FP16, 32'hffff0011, FLG_UNX);
      add_vec(28'hfff0000, 0, 0, OP_DIV, SP_NONE, RM_RNE, FP16, 32'hffff0400, FLG_UNX);
      add_vec(28'h8000000, -50, 0, OP_DIV, SP_NONE, RM_RUP, FP16, 32'hffff0001, FLG_UNX);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One request through the full four-phase handshake
  //////////////////////////////////////////////////////////////////////
  task run_entry(input int i);
    int extra;
    begin
      @(posedge clk);
      #1;
      check_val("ack", 32'd0, {31'b0, ack});  // One idle cycle with req low
      mant_in  = q_mant[i];
      exp_in   = q_exp[i];
      sign_in  = q_sign[i];
      {op_div, op_sqrt} = q_op[i];
      {nan_a, nan_b, snan, inf_a, inf_b, zero_a, zero_b} = q_spec[i];
      rnd_mode = q_rm[i];
      fmt_fp16 = q_fmt[i];
      req      = 1'b1;
      wait_for_ack(1'b1, i);
      check_val("result", q_res[i], result);
      check_val("fflags", {27'b0, q_flg[i]}, {27'b0, fflags});
      extra    = $urandom % 6;  // Back-pressure of 0 to 5 cycles
      repeat (extra)
      begin
        @(posedge clk);
        #1;
        check_val("result", q_res[i], result);  // Held under back-pressure
        check_val("fflags", {27'b0, q_flg[i]}, {27'b0, fflags});
        check_val("ack", 32'd1, {31'b0, ack});
      end
      req = 1'b0;
      wait_for_ack(1'b0, i);
    end
  endtask

  initial
  begin
    clk      = 1'b0;
    rst      = 1'b1;
    req      = 1'b0;
    mant_in  = '0;
    exp_in   = '0;
    sign_in  = 1'b0;
    op_div   = 1'b0;
    op_sqrt  = 1'b0;
    inf_a    = 1'b0;
    inf_b    = 1'b0;
    zero_a   = 1'b0;
    zero_b   = 1'b0;
    nan_a    = 1'b0;
    nan_b    = 1'b0;
    snan     = 1'b0;
    rnd_mode = RM_RNE;
    fmt_fp16 = 1'b0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    seed_val = $urandom(32'h2c9f);  // Seeds the generator once
    build_table();
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    check_val("ack", 32'd0, {31'b0, ack});  // Clean reset state
    check_val("result", 32'd0, result);
    check_val("fflags", 32'd0, {27'b0, fflags});
    // No request yet so ack stays low
    repeat (4)
    begin
      @(posedge clk);
      #1;
      check_val("ack", 32'd0, {31'b0, ack});
    end
    for (int i = 0; i < q_mant.size(); i++)
      run_entry(i);
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
logic/fp_fmt_pkg.sv
logic/norm_ctrl_pkg.sv
logic/norm_if.sv
logic/special_case_classify.sv
logic/denorm_shift_counter.sv
logic/mant_shift_reg.sv
logic/round_pack.sv
logic/norm_fsm.sv
logic/norm_round_top.sv
tb/tb_norm_round.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
  --top-module tb_norm_round -f sim.f -o tb_norm_round_sim

./obj_dir/tb_norm_round_sim | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
